//--- bench/clock_gen.sv
// ======================================
// clk156 source and power-on reset for the testbench
// ======================================
`timescale 1ns/1ps

module clock_gen
#(
   // half of the 40 ns period
   parameter int half_period = 20,
   // rising edges seen with reset held
   parameter int reset_cycles = 8
)
(
   output logic clk156,
   output logic hw_reset
);

   initial
   begin
      clk156 = 1'b0;
      forever
      begin
         #(half_period) clk156 = ~clk156;
      end
   end

   initial
   begin
      hw_reset = 1'b1;
      repeat (reset_cycles) @(posedge clk156);
      // let go on a falling edge, clear of the sampling edge
      @(negedge clk156);
      hw_reset = 1'b0;
   end

endmodule

//--- bench/xphy_int_tb.sv
// ======================================
// testbench for the xphy glue with random xgmii traffic
// checking runs in concurrent assertions on clk156
// ======================================
`timescale 1ns/1ps
`include "xphy_cfg.svh"

module xphy_int_tb;

   import xphy_pkg::*;

   localparam int sync_n = `XPHY_SYNC_STAGES;
   localparam int debounce_n = `XPHY_LINK_DEBOUNCE;
   // idle word as the cfg header defines it
   localparam xgmii_word_t idle_word = '{data: `XPHY_IDLE_DATA, ctrl: `XPHY_IDLE_CTRL};

   logic        clk156;
   logic        hw_reset;
   phy_status_t phy_status;
   logic [7:0]  core_status;
   xgmii_word_t mac_tx;
   xgmii_word_t phy_rx;
   xgmii_word_t phy_tx;
   xgmii_word_t mac_rx;
   logic        core_reset_tx;
   logic        core_reset_rx;
   logic        resetdone;
   logic        tx_axis_aresetn;
   logic        rx_axis_aresetn;
   logic        linkup;

   int check_errors = 0;
   int timeout_errors = 0;

   // reference model of the hold conditions and the sync latency
   logic              tx_hold;
   logic              rx_hold;
   // newest condition in bit 0 and oldest in the top bit
   logic [sync_n-1:0] tx_hist;
   logic [sync_n-1:0] rx_hist;
   logic              exp_core_tx;
   logic              exp_core_rx;
   logic              exp_link_ok;
   // consecutive qualifying edges saturating at the debounce length
   int                good_run;

   clock_gen clk_source
   (
      .clk156   (clk156),
      .hw_reset (hw_reset)
   );

   xphy_int xphy_int_inst
   (
      .clk156          (clk156),
      .hw_reset        (hw_reset),
      .phy_status      (phy_status),
      .core_status     (core_status),
      .mac_tx          (mac_tx),
      .phy_tx          (phy_tx),
      .phy_rx          (phy_rx),
      .mac_rx          (mac_rx),
      .core_reset_tx   (core_reset_tx),
      .core_reset_rx   (core_reset_rx),
      .resetdone       (resetdone),
      .tx_axis_aresetn (tx_axis_aresetn),
      .rx_axis_aresetn (rx_axis_aresetn),
      .linkup          (linkup)
   );

   assign tx_hold = !phy_status.tx_resetdone || phy_status.tx_fault || !phy_status.signal_detect;
   assign rx_hold = !phy_status.rx_resetdone || phy_status.tx_fault || !phy_status.signal_detect;
   // a core reset shows the condition from sync_n edges back
   assign exp_core_tx = tx_hist[sync_n-1];
   assign exp_core_rx = rx_hist[sync_n-1];
   assign exp_link_ok = core_status[0] && !exp_core_tx && !exp_core_rx;

   always_ff @(posedge clk156 or posedge hw_reset)
   begin
      if (hw_reset)
      begin
         // cores are expected held straight out of reset
         tx_hist  <= '1;
         rx_hist  <= '1;
         good_run <= 0;
      end
      else
      begin
         tx_hist[0] <= tx_hold;
         rx_hist[0] <= rx_hold;
         for (int i = 1; i < sync_n; i++)
         begin
            tx_hist[i] <= tx_hist[i-1];
            rx_hist[i] <= rx_hist[i-1];
         end
         if (!exp_link_ok)
            good_run <= 0;
         else if (good_run < debounce_n)
            good_run <= good_run + 1;
      end
   end

   task automatic report_mismatch(input string msg);
      check_errors++;
      $display("error at %0t: %s", $time, msg);
   endtask

   // held and idle through reset and on the first edge after it
   a_reset_state : assert property (@(posedge clk156)
      (hw_reset || $past(hw_reset)) |-> (core_reset_tx && core_reset_rx && !linkup &&
      !tx_axis_aresetn && !rx_axis_aresetn && phy_tx == idle_word && mac_rx == idle_word))
      else report_mismatch("outputs not in their reset state");

   a_core_tx : assert property (@(posedge clk156) disable iff (hw_reset)
      core_reset_tx == exp_core_tx)
      else report_mismatch("core_reset_tx does not follow its hold condition");

   a_core_rx : assert property (@(posedge clk156) disable iff (hw_reset)
      core_reset_rx == exp_core_rx)
      else report_mismatch("core_reset_rx does not follow its hold condition");

   // one cycle of latency with idle when the core was held at the sampling edge
   a_phy_tx : assert property (@(posedge clk156) disable iff (hw_reset)
      phy_tx == ($past(exp_core_tx) ? idle_word : $past(mac_tx)))
      else report_mismatch("phy_tx is not the previous mac_tx or idle");

   a_mac_rx : assert property (@(posedge clk156) disable iff (hw_reset)
      mac_rx == ($past(exp_core_rx) ? idle_word : $past(phy_rx)))
      else report_mismatch("mac_rx is not the previous phy_rx or idle");

   a_resetdone : assert property (@(posedge clk156)
      resetdone == (phy_status.tx_resetdone && phy_status.rx_resetdone))
      else report_mismatch("resetdone is not the and of both reset-done flags");

   a_aresetn : assert property (@(posedge clk156) disable iff (hw_reset)
      (tx_axis_aresetn && rx_axis_aresetn) == ($past(phy_status.tx_resetdone &&
      phy_status.rx_resetdone) && !$past(hw_reset)) && tx_axis_aresetn == rx_axis_aresetn)
      else report_mismatch("axi-stream resets do not trail resetdone by one cycle");

   a_linkup : assert property (@(posedge clk156) disable iff (hw_reset)
      linkup == (good_run >= debounce_n))
      else report_mismatch("linkup does not match the debounced link state");

   function automatic xgmii_word_t random_word();
      xgmii_word_t w;
      w.data = {$urandom(), $urandom()};
      w.ctrl = 8'($urandom());
      return w;
   endfunction

   // fresh words on both directions and then on to the next falling edge
   task automatic step_traffic(input int cycles);
      repeat (cycles)
      begin
         mac_tx = random_word();
         phy_rx = random_word();
         @(negedge clk156);
      end
   endtask

   task automatic wait_reset_release(input int limit);
      int n;
      n = 0;
      // hw_reset is stable at rising edges
      // an unknown level at time zero still counts as reset
      while (hw_reset !== 1'b0 && n < limit)
      begin
         @(posedge clk156);
         n++;
      end
      if (hw_reset !== 1'b0)
      begin
         timeout_errors++;
         $display("timeout: hw_reset was never released");
      end
      @(negedge clk156);
   endtask

   task automatic wait_core_state(input logic want_tx, input logic want_rx, input int limit);
      int n;
      n = 0;
      while ((core_reset_tx !== want_tx || core_reset_rx !== want_rx) && n < limit)
      begin
         step_traffic(1);
         n++;
      end
      if (core_reset_tx !== want_tx || core_reset_rx !== want_rx)
      begin
         timeout_errors++;
         $display("timeout: core resets never reached tx %b rx %b", want_tx, want_rx);
      end
   endtask

   task automatic wait_linkup(input int limit);
      int n;
      n = 0;
      while (linkup !== 1'b1 && n < limit)
      begin
         step_traffic(1);
         n++;
      end
      if (linkup !== 1'b1)
      begin
         timeout_errors++;
         $display("timeout: linkup never came up");
      end
   endtask

   initial
   begin
      phy_status  = '{tx_resetdone: 1'b0, rx_resetdone: 1'b0, tx_fault: 1'b0,
                      signal_detect: 1'b0};
      core_status = 8'h00;
      mac_tx      = '0;
      phy_rx      = '0;
      void'($urandom(32'hc8cc));
      wait_reset_release(20);
      // traffic while everything is still down must stay idle
      step_traffic(4);
      phy_status  = '{tx_resetdone: 1'b1, rx_resetdone: 1'b1, tx_fault: 1'b0,
                      signal_detect: 1'b1};
      core_status = 8'h01;
      wait_core_state(1'b0, 1'b0, sync_n + 4);
      wait_linkup(debounce_n + 4);
      // two single-cycle losses of block lock each restart the debounce
      step_traffic(3);
      core_status[0] = 1'b0;
      step_traffic(1);
      core_status[0] = 1'b1;
      step_traffic(6);
      core_status[0] = 1'b0;
      step_traffic(1);
      core_status[0] = 1'b1;
      wait_linkup(debounce_n + 4);
      // laser fault holds both directions
      phy_status.tx_fault = 1'b1;
      wait_core_state(1'b1, 1'b1, sync_n + 4);
      step_traffic(4);
      phy_status.tx_fault = 1'b0;
      wait_core_state(1'b0, 1'b0, sync_n + 4);
      wait_linkup(debounce_n + 4);
      // loss of signal holds both directions as well
      phy_status.signal_detect = 1'b0;
      wait_core_state(1'b1, 1'b1, sync_n + 4);
      step_traffic(4);
      phy_status.signal_detect = 1'b1;
      wait_core_state(1'b0, 1'b0, sync_n + 4);
      wait_linkup(debounce_n + 4);
      // receive transceiver alone drops out while tx keeps passing words
      phy_status.rx_resetdone = 1'b0;
      wait_core_state(1'b0, 1'b1, sync_n + 4);
      step_traffic(6);
      phy_status.rx_resetdone = 1'b1;
      wait_core_state(1'b0, 1'b0, sync_n + 4);
      wait_linkup(debounce_n + 4);
      step_traffic(4);
      $display("assertion errors: %0d, timeouts: %0d", check_errors, timeout_errors);
      if (check_errors == 0 && timeout_errors == 0)
      begin
         $display("sim passed");
      end
      else
      begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- hw/core_reset_gen.sv
// ======================================
// holds one direction's pcs core in reset
// until transceiver and optics are ready
// ======================================
`timescale 1ns/1ps
`include "xphy_cfg.svh"

module core_reset_gen
(
   input  logic clk156,
   input  logic hw_reset,
   // this direction's transceiver reset-done
   input  logic resetdone,
   // optics status, shared by both directions
   input  logic tx_fault,
   input  logic signal_detect,
   output logic core_reset
);

   // hold condition before synchronization
   logic hold_cond;

   // synchronizer chain, index 0 samples the raw condition
   logic [`XPHY_SYNC_STAGES-1:0] sync_q;

   // keep the core down while the transceiver is still resetting,
   // the laser is faulted or no light is seen
   assign hold_cond = !resetdone || tx_fault || !signal_detect;

   // chain is preset so the core starts held
   // release only ripples through on clock edges
   always_ff @(posedge clk156 or posedge hw_reset)
   begin
      if (hw_reset)
      begin
         // all ones, core held from the first edge
         sync_q <= '1;
      end
      else
      begin
         // first stage catches the asynchronous level
         sync_q[0] <= hold_cond;
         // remaining stages shift it along
         for (int i = 1; i < `XPHY_SYNC_STAGES; i++)
         begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   // last flop of the chain drives the core
   assign core_reset = sync_q[`XPHY_SYNC_STAGES-1];

   // a fault seen at the input must have put the core back
   // into reset once the whole chain has been walked
   property p_fault_forces_reset;
      @(posedge clk156) disable iff (hw_reset)
         tx_fault |-> ##(`XPHY_SYNC_STAGES) core_reset;
   endproperty

   a_fault_forces_reset : assert property (p_fault_forces_reset)
      else $error("core_reset low %0d cycles after tx_fault", `XPHY_SYNC_STAGES);

   // same for losing the received light
   property p_los_forces_reset;
      @(posedge clk156) disable iff (hw_reset)
         !signal_detect |-> ##(`XPHY_SYNC_STAGES) core_reset;
   endproperty

   a_los_forces_reset : assert property (p_los_forces_reset)
      else $error("core_reset low %0d cycles after signal loss", `XPHY_SYNC_STAGES);

endmodule

//--- hw/link_monitor.sv
// ======================================
// derives resetdone, the axi-stream resets
// and a debounced linkup for the mac side
// ======================================
`timescale 1ns/1ps
`include "xphy_cfg.svh"

module link_monitor
(
   input  logic                      clk156,
   input  logic                      hw_reset,
   // synchronized core resets from both directions
   input  logic                      core_reset_tx,
   input  logic                      core_reset_rx,
   input  xphy_pkg::phy_status_t     phy_status,
   // pcs status vector, bit 0 is block lock
   input  logic [7:0]                core_status,
   output logic                      resetdone,
   output logic                      tx_axis_aresetn,
   output logic                      rx_axis_aresetn,
   output logic                      linkup
);

   // counter wide enough for the full debounce length
   localparam int cnt_w = $clog2(`XPHY_LINK_DEBOUNCE + 1);

   // last count before linkup is allowed
   localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`XPHY_LINK_DEBOUNCE - 1);

   // block lock with both cores running
   logic link_ok;

   // consecutive good cycles seen so far
   logic [cnt_w-1:0] good_cnt;

   // both transceiver halves out of reset, no register on this path
   assign resetdone = phy_status.tx_resetdone && phy_status.rx_resetdone;

   assign link_ok = core_status[0] && !core_reset_tx && !core_reset_rx;

   // mac axi-stream resets follow resetdone one cycle later
   // low coming out of reset so the mac starts held
   always_ff @(posedge clk156 or posedge hw_reset)
   begin
      if (hw_reset)
      begin
         tx_axis_aresetn <= 1'b0;
         rx_axis_aresetn <= 1'b0;
      end
      else
      begin
         tx_axis_aresetn <= resetdone;
         rx_axis_aresetn <= resetdone;
      end
   end

   // debounce, linkup only after a full run of good cycles
   // any bad cycle drops linkup on the next edge and restarts the run
   always_ff @(posedge clk156 or posedge hw_reset)
   begin
      if (hw_reset)
      begin
         good_cnt <= '0;
         linkup   <= 1'b0;
      end
      else if (!link_ok)
      begin
         // lock lost or a core went back into reset
         good_cnt <= '0;
         linkup   <= 1'b0;
      end
      else if (good_cnt == cnt_last)
      begin
         // run complete, counter parks here while the link holds
         linkup <= 1'b1;
      end
      else
      begin
         good_cnt <= good_cnt + 1'b1;
      end
   end

   // linkup trails link_ok by a cycle,
   // so it may only be high if both cores were running one cycle earlier
   property p_linkup_needs_cores;
      @(posedge clk156) disable iff (hw_reset)
         linkup |-> $past(!core_reset_tx && !core_reset_rx);
   endproperty

   a_linkup_needs_cores : assert property (p_linkup_needs_cores)
      else $error("linkup high while a core was in reset");

endmodule

//--- hw/xgmii_stage.sv
// ======================================
// one-cycle xgmii register stage
// sends idle while its direction is held
// ======================================
`timescale 1ns/1ps

module xgmii_stage
#(
   // word format carried through the stage
   parameter type payload_t = xphy_pkg::xgmii_word_t,
   // word sent while held
   // the parent passes in the link's idle encoding
   parameter payload_t IDLE = '0
)
(
   input  logic     clk156,
   input  logic     hw_reset,
   // direction's core reset replaces traffic with idle
   input  logic     hold,
   input  payload_t din,
   output payload_t dout
);

   // one word in flight and a new one taken every cycle
   // no stall path since the mac and phy both run freely at 156.25 MHz
   always_ff @(posedge clk156 or posedge hw_reset)
   begin
      if (hw_reset)
      begin
         // link sees idle straight out of reset
         dout <= IDLE;
      end
      else if (hold)
      begin
         // core in reset so whatever arrives is dropped
         // and the far end only ever sees clean idle
         dout <= IDLE;
      end
      else
      begin
         // normal pass-through with one cycle of latency
         dout <= din;
      end
   end

   // a held cycle must be followed by idle on the output
   // checks the hold path and the register together
   property p_hold_gives_idle;
      @(posedge clk156) disable iff (hw_reset)
         hold |=> (dout == IDLE);
   endproperty

   a_hold_gives_idle : assert property (p_hold_gives_idle)
      else $error("xgmii stage passed data while held");

endmodule

//--- hw/xphy_cfg.svh
// ======================================
// build-time constants for the xphy glue
// include wherever a depth or encoding is needed
// ======================================
`ifndef XPHY_CFG_SVH
`define XPHY_CFG_SVH

// flops in each core reset synchronizer chain
`define XPHY_SYNC_STAGES 2

// consecutive good cycles before linkup is reported
`define XPHY_LINK_DEBOUNCE 16

// xgmii idle is the /I/ character 07 hex in all eight lanes
`define XPHY_IDLE_DATA 64'h0707_0707_0707_0707

// every lane flagged as a control character
`define XPHY_IDLE_CTRL 8'hff

`endif

//--- hw/xphy_int.sv
// ======================================
// glue between 10g mac and 10gbase-r phy core
// reset sequencing, xgmii registers, link status
// ======================================
`timescale 1ns/1ps
`include "xphy_cfg.svh"

module xphy_int
(
   input  logic                  clk156,
   input  logic                  hw_reset,

   // transceiver and optics status
   input  xphy_pkg::phy_status_t phy_status,
   // pcs core status vector
   input  logic [7:0]            core_status,

   // transmit xgmii, mac in and phy out
   input  xphy_pkg::xgmii_word_t mac_tx,
   output xphy_pkg::xgmii_word_t phy_tx,

   // receive xgmii, phy in and mac out
   input  xphy_pkg::xgmii_word_t phy_rx,
   output xphy_pkg::xgmii_word_t mac_rx,

   // per-direction pcs core resets
   output logic                  core_reset_tx,
   output logic                  core_reset_rx,

   // mac-side reset and link indications
   output logic                  resetdone,
   output logic                  tx_axis_aresetn,
   output logic                  rx_axis_aresetn,
   output logic                  linkup
);

   import xphy_pkg::*;

   // idle word sent in place of traffic on a held direction
   localparam xgmii_word_t xgmii_idle = '{
      data: `XPHY_IDLE_DATA,
      ctrl: `XPHY_IDLE_CTRL
   };

   // transmit core waits on its own reset-done plus the optics
   core_reset_gen tx_reset_gen
   (
      .clk156        (clk156),
      .hw_reset      (hw_reset),
      .resetdone     (phy_status.tx_resetdone),
      .tx_fault      (phy_status.tx_fault),
      .signal_detect (phy_status.signal_detect),
      .core_reset    (core_reset_tx)
   );

   // receive core, same optics gating
   // a laser fault also holds rx since the link is useless without tx
   core_reset_gen rx_reset_gen
   (
      .clk156        (clk156),
      .hw_reset      (hw_reset),
      .resetdone     (phy_status.rx_resetdone),
      .tx_fault      (phy_status.tx_fault),
      .signal_detect (phy_status.signal_detect),
      .core_reset    (core_reset_rx)
   );

   // mac to phy register, idle while the tx core is held
   xgmii_stage
   #(
      .payload_t (xgmii_word_t),
      .IDLE      (xgmii_idle)
   )
   tx_stage
   (
      .clk156   (clk156),
      .hw_reset (hw_reset),
      .hold     (core_reset_tx),
      .din      (mac_tx),
      .dout     (phy_tx)
   );

   // phy to mac register, idle while the rx core is held
   // keeps garbage from a resetting pcs away from the mac
   xgmii_stage
   #(
      .payload_t (xgmii_word_t),
      .IDLE      (xgmii_idle)
   )
   rx_stage
   (
      .clk156   (clk156),
      .hw_reset (hw_reset),
      .hold     (core_reset_rx),
      .din      (phy_rx),
      .dout     (mac_rx)
   );

   // combined status toward the mac
   link_monitor link_monitor
   (
      .clk156          (clk156),
      .hw_reset        (hw_reset),
      .core_reset_tx   (core_reset_tx),
      .core_reset_rx   (core_reset_rx),
      .phy_status      (phy_status),
      .core_status     (core_status),
      .resetdone       (resetdone),
      .tx_axis_aresetn (tx_axis_aresetn),
      .rx_axis_aresetn (rx_axis_aresetn),
      .linkup          (linkup)
   );

endmodule

//--- hw/xphy_pkg.sv
// ======================================
// shared types for the mac to phy glue
// ======================================
package xphy_pkg;

   // one xgmii transfer at 156.25 MHz
   // eight byte lanes, lane 0 in data[7:0] and ctrl[0]
   // a set ctrl bit marks that lane as a control character
   typedef struct packed {
      // lane 7 down to lane 0
      logic [63:0] data;
      // one control flag per lane
      logic [7:0]  ctrl;
   } xgmii_word_t;

   // status levels coming back from the transceiver and optics
   // all of these are asynchronous to clk156 in the real board
   // and get resampled by the core reset chains
   typedef struct packed {
      // transmit side of the transceiver finished its reset
      logic tx_resetdone;
      // receive side of the transceiver finished its reset
      logic rx_resetdone;
      // sfp module reports a laser fault
      logic tx_fault;
      // sfp module sees light on the receive fibre
      logic signal_detect;
   } phy_status_t;

   // field order above sets the packed layout
   // msb is tx_resetdone and lsb is signal_detect
   // keep it in step with any board-level pin mapping

   // the xgmii word is 72 bits wide
   // data sits in the upper 64 bits and ctrl in the lower 8

   // both types are plain levels
   // no valid or ready travels with them since the link never stalls

   // payload handling is generic in the register stage
   // so other word formats can reuse it through its type parameter

endpackage

//--- run_sim.sh
#!/bin/sh
# build the xphy testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f sim.f --top-module xphy_int_tb -Mdir obj_dir

out=$(./obj_dir/Vxphy_int_tb)
echo "$out"

# pass only if the testbench printed the pass line
if echo "$out" | grep -qx "sim passed"; then
   exit 0
else
   exit 1
fi

//--- sim.f
+incdir+hw
hw/xphy_pkg.sv
hw/core_reset_gen.sv
hw/xgmii_stage.sv
hw/link_monitor.sv
hw/xphy_int.sv
bench/clock_gen.sv
bench/xphy_int_tb.sv
